// File: files.f
+incdir+hw
hw/issue_pkg.sv
hw/inst_fetch.sv
hw/inst_decode.sv
hw/issue_queue.sv
hw/issue_select.sv
hw/issue_top.sv
tests/issue_tb.sv

// File: hw/inst_decode.sv
`timescale 1ns/1ns

module inst_decode (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_flush,
    input  issue_pkg::fetch_pair_t i_pair,
    output issue_pkg::dec_inst_t   o_inst0,
    output issue_pkg::dec_inst_t   o_inst1
);
    import issue_pkg::*;

    dec_inst_t  dec0_q;
    dec_inst_t  dec1_q;
    logic [1:0] vld_q;

    // one word into one record, valid is filled in by the caller
    function automatic dec_inst_t decode_word(input word_t w, input addr_t pc);
        dec_inst_t   d;
        logic [16:0] op_3r;
        logic [9:0]  op_2ri;
        op_3r    = w[31:15];
        op_2ri   = w[31:22];
        d        = '0;
        d.pc     = pc;
        d.op     = OP_ILLEGAL;
        d.sub_op = SUB_NONE;
        d.rd     = w[4:0];
        d.rj     = w[9:5];
        d.rk     = w[14:10];

        // three-register forms
        case (op_3r)
            17'h00020: d.sub_op = SUB_ADD;
            17'h00022: d.sub_op = SUB_SUB;
            17'h00029: d.sub_op = SUB_AND;
            17'h0002a: d.sub_op = SUB_OR;
            default: ;
        endcase
        if (d.sub_op != SUB_NONE) begin
            d.op       = OP_ALU;
            d.rd_we    = 1'b1;
            d.reads_rk = 1'b1;
        end

        // 12-bit immediate forms
        case (op_2ri)
            10'h00a: begin
                d.op     = OP_ALU;
                d.sub_op = SUB_ADDI;
                d.rd_we  = 1'b1;
            end
            10'h0a2: begin
                d.op     = OP_LOAD;
                d.sub_op = SUB_LD;
                d.rd_we  = 1'b1;
            end
            10'h0a6: begin
                d.op       = OP_STORE;
                d.sub_op   = SUB_ST;
                d.reads_rd = 1'b1;
            end
            default: ;
        endcase
        if (d.sub_op == SUB_ADDI || d.sub_op == SUB_LD || d.sub_op == SUB_ST) begin
            d.imm = {{20{w[21]}}, w[21:10]};
        end

        d.rd_we = d.rd_we && (d.rd != 5'd0); // r0 is never written
        return d;
    endfunction

    always_ff @(posedge clk) begin
        if (i_pair.valid) begin
            dec0_q <= decode_word(i_pair.word0, i_pair.pc);
            dec1_q <= decode_word(i_pair.word1, i_pair.pc + 32'd4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            vld_q <= 2'b00;
        end else if (i_flush) begin
            vld_q <= 2'b00;       // drop the pair in flight
        end else begin
            vld_q <= {2{i_pair.valid}};
        end
    end

    // slot 0 is the older word
    always_comb begin
        o_inst0       = dec0_q;
        o_inst0.valid = vld_q[0];
        o_inst1       = dec1_q;
        o_inst1.valid = vld_q[1];
    end

endmodule

// File: hw/inst_fetch.sv
`timescale 1ns/1ns
`include "issue_params.svh"

module inst_fetch (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_flush,
    input  issue_pkg::addr_t       i_flush_pc,
    input  logic                   i_iq_full,
    output logic                   o_wb_cyc,
    output logic                   o_wb_stb,
    output logic                   o_wb_we,
    output logic [3:0]             o_wb_sel,
    output issue_pkg::addr_t       o_wb_adr,
    input  issue_pkg::word_t       i_wb_dat,
    input  logic                   i_wb_ack,
    output issue_pkg::fetch_pair_t o_pair
);
    import issue_pkg::*;

    fetch_state_e state;
    addr_t        pc;         // address of the next pair
    addr_t        adr_q;
    word_t        word0_q;
    word_t        word1_q;
    addr_t        pair_pc;
    logic         pair_valid;
    logic         discard;    // open transfer belongs to a flushed stream
    logic         bus_open;

    assign bus_open = (state == FS_WORD0) || (state == FS_WORD1);

    // read-only master, full word lanes
    assign o_wb_cyc = bus_open;
    assign o_wb_stb = bus_open;
    assign o_wb_we  = 1'b0;
    assign o_wb_sel = 4'hf;
    assign o_wb_adr = adr_q;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= FS_IDLE;
            pc         <= `RESET_PC;
            discard    <= 1'b0;
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= 1'b0;
            if (i_flush) begin
                pc <= i_flush_pc;
                if (bus_open && !i_wb_ack) begin
                    discard <= 1'b1; // let the slave finish first
                end else begin
                    state   <= FS_IDLE;
                    discard <= 1'b0;
                end
            end else begin
                case (state)
                    FS_IDLE, FS_HOLD: begin
                        if (!i_iq_full) state <= FS_WORD0;
                    end
                    FS_WORD0: begin
                        if (i_wb_ack) begin
                            state   <= discard ? FS_IDLE : FS_WORD1;
                            discard <= 1'b0;
                        end
                    end
                    FS_WORD1: begin
                        if (i_wb_ack && discard) begin
                            state   <= FS_IDLE;
                            discard <= 1'b0;
                        end else if (i_wb_ack) begin
                            state      <= FS_HOLD; // cyc drops for at least a cycle
                            pc         <= pc + 32'd8;
                            pair_valid <= 1'b1;
                        end
                    end
                    default: state <= FS_IDLE;
                endcase
            end
        end
    end

    // address and captured words
    always_ff @(posedge clk) begin
        if (!bus_open) begin
            adr_q <= pc;
        end else if (state == FS_WORD0 && i_wb_ack) begin
            adr_q   <= adr_q + 32'd4;
            word0_q <= i_wb_dat;
        end
        if (state == FS_WORD1 && i_wb_ack) begin
            word1_q <= i_wb_dat;
            pair_pc <= pc;
        end
    end

    always_comb begin
        o_pair.valid = pair_valid;
        o_pair.pc    = pair_pc;
        o_pair.word0 = word0_q;
        o_pair.word1 = word1_q;
    end

    // a request keeps its address until the slave acknowledges it
    a_adr_stable: assert property (@(posedge clk) disable iff (!rstn)
        (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr)))
        else $error("fetch address changed during an open request");

endmodule

// File: hw/issue_params.svh
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// issue queue geometry
//////////////////////////////////////////////////////////////////////

// number of decoded records the queue can hold
`define IQ_DEPTH 16

// free slots held back before full is raised
// one pair in decode, one in the fetch register, one on the bus
`define IQ_FULL_MARGIN 6

//////////////////////////////////////////////////////////////////////
// fetch
//////////////////////////////////////////////////////////////////////

`define RESET_PC 32'h1c00_0000 // first fetch address out of reset

`endif

// File: hw/issue_pkg.sv
package issue_pkg;

    typedef logic [31:0] addr_t;    // byte address
    typedef logic [31:0] word_t;    // instruction or data word
    typedef logic [4:0]  reg_idx_t; // architectural register
    typedef logic [31:0] imm_t;     // sign-extended immediate
    typedef logic [3:0]  sub_op_t;

    typedef enum logic [1:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_ILLEGAL
    } op_class_e;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_WORD0,
        FS_WORD1,
        FS_HOLD
    } fetch_state_e;

    // sub-operation codes inside an op class
    localparam sub_op_t SUB_ADD  = 4'd0;
    localparam sub_op_t SUB_SUB  = 4'd1;
    localparam sub_op_t SUB_AND  = 4'd2;
    localparam sub_op_t SUB_OR   = 4'd3;
    localparam sub_op_t SUB_ADDI = 4'd4;
    localparam sub_op_t SUB_LD   = 4'd5;
    localparam sub_op_t SUB_ST   = 4'd6;
    localparam sub_op_t SUB_NONE = 4'd15; // illegal words

    typedef struct packed {
        logic  valid;
        addr_t pc;    // address of word0
        word_t word0;
        word_t word1;
    } fetch_pair_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        op_class_e op;
        sub_op_t   sub_op;
        reg_idx_t  rd;
        reg_idx_t  rj;
        reg_idx_t  rk;
        logic      rd_we;    // never set for r0
        imm_t      imm;
        logic      reads_rk;
        logic      reads_rd; // st.w data source
    } dec_inst_t;

endpackage

// File: hw/issue_queue.sv
`timescale 1ns/1ns
`include "issue_params.svh"

module issue_queue (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_flush,
    input  issue_pkg::dec_inst_t i_inst0,
    input  issue_pkg::dec_inst_t i_inst1,
    input  logic [1:0]           i_pop_num,
    output issue_pkg::dec_inst_t o_head0,
    output issue_pkg::dec_inst_t o_head1,
    output logic                 o_full
);
    import issue_pkg::*;

    localparam int PTR_W = $clog2(`IQ_DEPTH);
    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

    localparam logic [PTR_W:0] DEPTH_P   = (PTR_W + 1)'(`IQ_DEPTH);
    localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(`IQ_DEPTH);
    localparam logic [CNT_W-1:0] FULL_AT = CNT_W'(`IQ_DEPTH - `IQ_FULL_MARGIN);

    dec_inst_t        mem [`IQ_DEPTH]; // record storage
    logic [PTR_W-1:0] head;            // oldest entry
    logic [PTR_W-1:0] tail;            // next free slot
    logic [PTR_W-1:0] head_p1;
    logic [PTR_W-1:0] tail_p1;
    logic [PTR_W-1:0] head_next;
    logic [PTR_W-1:0] tail_next;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic [1:0]       push_num;

    // pointer advance, wraps modulo the depth
    function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] p,
                                                 input logic [1:0] n);
        logic [PTR_W:0] sum;
        sum = {1'b0, p} + (PTR_W + 1)'(n);
        if (sum >= DEPTH_P) begin
            sum = sum - DEPTH_P;
        end
        return sum[PTR_W-1:0];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // occupancy
    //////////////////////////////////////////////////////////////////////
    assign push_num   = {1'b0, i_inst0.valid} + {1'b0, i_inst1.valid};
    assign head_p1    = ptr_add(head, 2'd1);
    assign tail_p1    = ptr_add(tail, 2'd1);
    assign head_next  = ptr_add(head, i_pop_num);
    assign tail_next  = ptr_add(tail, push_num);
    assign count_next = count - CNT_W'(i_pop_num) + CNT_W'(push_num);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            o_full <= 1'b0;
        end else if (i_flush) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            o_full <= 1'b0;
        end else begin
            head   <= head_next;
            tail   <= tail_next;
            count  <= count_next;
            o_full <= (count_next >= FULL_AT); // stops fetch early
        end
    end

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!i_flush) begin
            if (i_inst0.valid) begin
                mem[tail] <= i_inst0;
            end
            if (i_inst1.valid) begin
                mem[i_inst0.valid ? tail_p1 : tail] <= i_inst1; // keep program order
            end
        end
    end

    // two oldest entries, valid from the count
    always_comb begin
        o_head0       = mem[head];
        o_head0.valid = (count != '0);
        o_head1       = mem[head_p1];
        o_head1.valid = (count > CNT_W'(1));
    end

    // the selector only pops what the heads showed as valid
    a_pop_le_count: assert property (@(posedge clk) disable iff (!rstn || i_flush)
        CNT_W'(i_pop_num) <= count)
        else $error("issue queue popped more records than it holds");

    // the full margin has to cover everything already past the fetch check
    a_no_overrun: assert property (@(posedge clk) disable iff (!rstn || i_flush)
        (count + CNT_W'(push_num)) <= DEPTH_C)
        else $error("issue queue written beyond its depth");

endmodule

// File: hw/issue_select.sv
`timescale 1ns/1ns

module issue_select (
    input  logic                 i_stall,
    input  issue_pkg::dec_inst_t i_head0,
    input  issue_pkg::dec_inst_t i_head1,
    output logic [1:0]           o_pop_num,
    output logic [1:0]           o_issue_valid
);
    import issue_pkg::*;

    logic mem0;
    logic mem1;
    logic raw_hazard;
    logic pair_ok;
    logic issue_a;

    always_comb begin
        mem0 = (i_head0.op == OP_LOAD) || (i_head0.op == OP_STORE);
        mem1 = (i_head1.op == OP_LOAD) || (i_head1.op == OP_STORE);

        // legal records always read rj
        raw_hazard = i_head0.rd_we &&
                     ((i_head1.rj == i_head0.rd) ||
                      (i_head1.reads_rk && (i_head1.rk == i_head0.rd)) ||
                      (i_head1.reads_rd && (i_head1.rd == i_head0.rd)));

        pair_ok = i_head1.valid &&
                  (i_head0.op != OP_ILLEGAL) &&
                  (i_head1.op != OP_ILLEGAL) && // illegal issues alone
                  !(mem0 && mem1) &&              // one memory port
                  !raw_hazard;

        issue_a       = i_head0.valid && !i_stall;
        o_issue_valid = {issue_a && pair_ok, issue_a};
        o_pop_num     = {1'b0, o_issue_valid[0]} + {1'b0, o_issue_valid[1]};

        // slot B is always the word right after slot A in the queue
        if (o_issue_valid[1]) begin
            a_pair_order: assert (o_issue_valid[0] && (i_head1.pc == i_head0.pc + 32'd4))
                else $error("slot B issued without slot A or out of order");
        end
    end

endmodule

// File: hw/issue_top.sv
`timescale 1ns/1ns

module issue_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_stall,
    input  logic                 i_flush,
    input  issue_pkg::addr_t     i_flush_pc,
    output logic                 o_wb_cyc,
    output logic                 o_wb_stb,
    output logic                 o_wb_we,
    output logic [3:0]           o_wb_sel,
    output issue_pkg::addr_t     o_wb_adr,
    input  issue_pkg::word_t     i_wb_dat,
    input  logic                 i_wb_ack,
    output issue_pkg::dec_inst_t o_issue_a,
    output issue_pkg::dec_inst_t o_issue_b,
    output logic [1:0]           o_issue_valid
);
    import issue_pkg::*;

    fetch_pair_t pair;
    dec_inst_t   inst0;
    dec_inst_t   inst1;
    dec_inst_t   head0;
    dec_inst_t   head1;
    logic [1:0]  pop_num;
    logic        iq_full;

    //////////////////////////////////////////////////////////////////////
    // fetch -> decode -> queue -> select
    //////////////////////////////////////////////////////////////////////
    inst_fetch u_fetch (
        .clk        (clk),
        .rstn       (rstn),
        .i_flush    (i_flush),
        .i_flush_pc (i_flush_pc),
        .i_iq_full  (iq_full),
        .o_wb_cyc   (o_wb_cyc),
        .o_wb_stb   (o_wb_stb),
        .o_wb_we    (o_wb_we),
        .o_wb_sel   (o_wb_sel),
        .o_wb_adr   (o_wb_adr),
        .i_wb_dat   (i_wb_dat),
        .i_wb_ack   (i_wb_ack),
        .o_pair     (pair)
    );

    inst_decode u_decode (
        .clk     (clk),
        .rstn    (rstn),
        .i_flush (i_flush),
        .i_pair  (pair),
        .o_inst0 (inst0),
        .o_inst1 (inst1)
    );

    issue_queue u_queue (
        .clk       (clk),
        .rstn      (rstn),
        .i_flush   (i_flush),
        .i_inst0   (inst0),
        .i_inst1   (inst1),
        .i_pop_num (pop_num),
        .o_head0   (head0),
        .o_head1   (head1),
        .o_full    (iq_full)
    );

    issue_select u_select (
        .i_stall       (i_stall),
        .i_head0       (head0),
        .i_head1       (head1),
        .o_pop_num     (pop_num),
        .o_issue_valid (o_issue_valid)
    );

    // issue slots are the queue heads
    assign o_issue_a = head0;
    assign o_issue_b = head1;

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module issue_tb -o issue_sim

out=$(./obj_dir/issue_sim)
echo "$out"

grep -q "All tests passed" <<< "$out"

// File: tests/issue_tb.sv
`timescale 1ns/1ns
`include "issue_params.svh"

module issue_tb;
    import issue_pkg::*;

    localparam int    TABLE_N   = 96;
    localparam addr_t TABLE_END = `RESET_PC + 32'(4 * TABLE_N);
    localparam addr_t FLUSH_PC  = `RESET_PC + 32'h40; // rewinds into words already issued
    localparam int    FLUSH_AT  = 40;                 // issued count that triggers the flush
    localparam int    LONG_AT   = 80;
    localparam int    LONG_LEN  = 80;
    // about 130 issued words at up to 8 cycles a pair plus stalls, four times over
    localparam int MAX_CYCLES = 4000;

    logic        clk = 1'b0;
    logic        rstn;
    logic        stall;
    logic        flush;
    addr_t       flush_pc;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_sel;
    addr_t       wb_adr;
    word_t       wb_dat;
    logic        wb_ack;
    dec_inst_t   issue_a;
    dec_inst_t   issue_b;
    logic [1:0]  issue_valid;

    word_t       prog [TABLE_N]; // program image and reference copy
    logic [15:0] lfsr = 16'd82;
    addr_t       exp_pc = `RESET_PC;
    int          n_issued = 0;
    int          cycle_cnt = 0;
    int          wait_left = 0;
    int          long_left = 0;
    int          full_cycles = 0;
    int          val_errors = 0;
    int          other_errors = 0;
    logic        flush_done = 1'b0;
    logic        long_done = 1'b0;
    logic        saw_full = 1'b0;
    logic        run_done = 1'b0;

    issue_top dut0 (
        .clk           (clk),
        .rstn          (rstn),
        .i_stall       (stall),
        .i_flush       (flush),
        .i_flush_pc    (flush_pc),
        .o_wb_cyc      (wb_cyc),
        .o_wb_stb      (wb_stb),
        .o_wb_we       (wb_we),
        .o_wb_sel      (wb_sel),
        .o_wb_adr      (wb_adr),
        .i_wb_dat      (wb_dat),
        .i_wb_ack      (wb_ack),
        .o_issue_a     (issue_a),
        .o_issue_b     (issue_b),
        .o_issue_valid (issue_valid)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // random bits from x^16 + x^14 + x^13 + x^11 + 1
    //////////////////////////////////////////////////////////////////////
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[14:0], lfsr_step()};
        end
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // program table and memory contents
    //////////////////////////////////////////////////////////////////////
    function automatic logic [16:0] alu_opcode(input logic [1:0] sel);
        case (sel)
            2'd0:    return 17'h00020; // add.w
            2'd1:    return 17'h00022; // sub.w
            2'd2:    return 17'h00029; // and
            default: return 17'h0002a; // or
        endcase
    endfunction

    function automatic word_t enc_3r(input logic [16:0] op, input reg_idx_t rd,
                                     input reg_idx_t rj, input reg_idx_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic word_t enc_2ri(input logic [9:0] op, input logic [11:0] imm,
                                      input reg_idx_t rj, input reg_idx_t rd);
        return {op, imm, rj, rd};
    endfunction

    task automatic build_table();
        reg_idx_t    rd;
        reg_idx_t    rj;
        reg_idx_t    rk;
        reg_idx_t    last_rd;
        logic [11:0] imm;
        logic [2:0]  kind;
        last_rd = '0;
        for (int i = 0; i < TABLE_N; i++) begin
            kind = 3'(rand_bits(3));
            rd   = 5'(rand_bits(3)); // few registers so hazards come often
            rj   = 5'(rand_bits(3));
            rk   = 5'(rand_bits(3));
            imm  = 12'(rand_bits(12));
            case (kind)
                3'd0, 3'd1: prog[i] = enc_3r(alu_opcode(2'(rand_bits(2))), rd, rj, rk);
                3'd2:       prog[i] = enc_2ri(10'h00a, imm, rj, rd);
                3'd3:       prog[i] = enc_2ri(10'h0a2, imm, rj, rd); // ld.w
                3'd4:       prog[i] = enc_2ri(10'h0a6, imm, rj, rd); // st.w
                3'd5:       prog[i] = enc_3r(17'h00020, rd, last_rd, rk);
                3'd6:       prog[i] = 32'hffc0_0000 | 32'(i); // unknown opcode
                default:    prog[i] = enc_2ri(10'h00a, imm, last_rd, rd);
            endcase
            last_rd = rd;
        end
    endtask

    // outside the table every word is the inverted address
    function automatic word_t word_at(input addr_t adr);
        addr_t idx;
        idx = (adr - `RESET_PC) >> 2;
        if (adr >= `RESET_PC && idx < 32'(TABLE_N)) begin
            return prog[idx];
        end
        return ~adr;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference decode and pairing rules
    //////////////////////////////////////////////////////////////////////
    function automatic sub_op_t classify(input word_t w);
        case (w[31:15])
            17'h00020: return SUB_ADD;
            17'h00022: return SUB_SUB;
            17'h00029: return SUB_AND;
            17'h0002a: return SUB_OR;
            default: ;
        endcase
        case (w[31:22])
            10'h00a: return SUB_ADDI;
            10'h0a2: return SUB_LD;
            10'h0a6: return SUB_ST;
            default: return SUB_NONE;
        endcase
    endfunction

    function automatic dec_inst_t expect_record(input addr_t pc);
        word_t     w;
        sub_op_t   s;
        dec_inst_t e;
        w          = word_at(pc);
        s          = classify(w);
        e          = '0;
        e.valid    = 1'b1;
        e.pc       = pc;
        e.sub_op   = s;
        e.rd       = w[4:0];
        e.rj       = w[9:5];
        e.rk       = w[14:10];
        e.op       = (s == SUB_NONE) ? OP_ILLEGAL :
                     (s == SUB_LD)   ? OP_LOAD    :
                     (s == SUB_ST)   ? OP_STORE   : OP_ALU;
        e.reads_rk = s inside {SUB_ADD, SUB_SUB, SUB_AND, SUB_OR};
        e.reads_rd = (s == SUB_ST);
        e.rd_we    = (s != SUB_NONE) && (s != SUB_ST) && (w[4:0] != 5'd0);
        if (s inside {SUB_ADDI, SUB_LD, SUB_ST}) begin
            e.imm = {{20{w[21]}}, w[21:10]};
        end
        return e;
    endfunction

    function automatic logic pairable(input dec_inst_t a, input dec_inst_t b);
        logic mem_a;
        logic mem_b;
        logic raw;
        mem_a = (a.op == OP_LOAD) || (a.op == OP_STORE);
        mem_b = (b.op == OP_LOAD) || (b.op == OP_STORE);
        raw   = a.rd_we && ((b.rj == a.rd) || (b.reads_rk && b.rk == a.rd) ||
                            (b.reads_rd && b.rd == a.rd));
        return (a.op != OP_ILLEGAL) && (b.op != OP_ILLEGAL) && !(mem_a && mem_b) && !raw;
    endfunction

    task automatic value_fail(input string name, input logic [127:0] got,
                              input logic [127:0] want);
        $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, want);
        val_errors++;
    endtask

    task automatic other_fail(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        other_errors++;
    endtask

    // Wishbone slave with 0 to 2 wait states per word
    task automatic serve_bus();
        if (wb_cyc && wb_stb && wait_left == 0) begin
            wb_ack    = 1'b1;
            wb_dat    = word_at(wb_adr);
            wait_left = int'(rand_bits(2)) % 3;
        end else begin
            wb_ack = 1'b0;
            if (wb_cyc && wb_stb) begin
                wait_left--;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks on the falling edge where everything has settled
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        dec_inst_t exp_a;
        dec_inst_t exp_b;
        if (rstn === 1'b1 && !run_done) begin
            exp_a       = expect_record(exp_pc);
            exp_b       = expect_record(exp_pc + 32'd4);
            full_cycles = dut0.iq_full ? full_cycles + 1 : 0;
            if (long_left != 0 && full_cycles > 8) begin
                saw_full = 1'b1;
            end

            a_read_only: assert (!(wb_cyc && (wb_we || wb_sel != 4'hf)))
                else other_fail("fetch bus cycle is not a full-word read");
            a_stb_cyc: assert (wb_stb == wb_cyc)
                else other_fail("bus strobe and bus cycle are not asserted together");
            a_adr_word: assert (!(wb_cyc && wb_adr[1:0] != 2'b00))
                else value_fail("o_wb_adr[1:0]", 128'(wb_adr[1:0]), 128'd0);
            a_stall_quiet: assert (!(stall && issue_valid != 2'b00))
                else value_fail("o_issue_valid", 128'(issue_valid), 128'd0);
            a_b_needs_a: assert (issue_valid != 2'b10)
                else other_fail("slot B issued without slot A");
            a_no_idle: assert (!(!stall && issue_a.valid && !issue_valid[0]))
                else other_fail("a pending instruction was held back without stall");
            a_fetch_halted: assert (!(full_cycles > 8 && wb_cyc))
                else other_fail("fetch kept reading while the queue was full");

            if (issue_valid[0]) begin
                a_pc_a: assert (issue_a.pc == exp_pc)
                    else value_fail("o_issue_a.pc", 128'(issue_a.pc), 128'(exp_pc));
                a_rec_a: assert (issue_a == exp_a)
                    else value_fail("o_issue_a", 128'(issue_a), 128'(exp_a));
                a_pairing: assert (issue_valid[1] == (issue_b.valid && pairable(exp_a, exp_b)))
                    else value_fail("o_issue_valid[1]", 128'(issue_valid[1]),
                                    128'(issue_b.valid && pairable(exp_a, exp_b)));
            end
            if (issue_valid[1]) begin
                a_rec_b: assert (issue_b == exp_b)
                    else value_fail("o_issue_b", 128'(issue_b), 128'(exp_b));
            end

            if (flush) begin
                exp_pc = flush_pc; // stream restarts here
            end else begin
                exp_pc   = exp_pc + (issue_valid[1] ? 32'd8 : issue_valid[0] ? 32'd4 : 32'd0);
                n_issued = n_issued + (issue_valid[1] ? 2 : issue_valid[0] ? 1 : 0);
            end
            if (flush_done && exp_pc >= TABLE_END) begin
                run_done = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        rstn     = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        flush_pc = '0;
        wb_dat   = '0;
        wb_ack   = 1'b0;
        build_table();
        repeat (3) @(posedge clk);
        #1 rstn = 1'b1;

        while (!run_done && cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            #1;
            cycle_cnt++;
            serve_bus();
            flush = 1'b0;
            if (!flush_done && n_issued >= FLUSH_AT) begin
                flush      = 1'b1;
                flush_pc   = FLUSH_PC;
                stall      = 1'b1; // nothing issues in the flush cycle
                flush_done = 1'b1;
            end else if (long_left != 0) begin
                stall = 1'b1;
                long_left--;
            end else if (flush_done && !long_done && n_issued >= LONG_AT) begin
                stall     = 1'b1;  // long enough to fill the queue
                long_left = LONG_LEN;
                long_done = 1'b1;
            end else begin
                stall = (rand_bits(2) == 16'd3);
            end
        end

        if (!run_done) begin
            other_fail("timeout before the whole table was issued");
        end
        a_queue_filled: assert (saw_full)
            else other_fail("the long stall never filled the queue");
        $display("%0d value errors, %0d other errors", val_errors, other_errors);
        if (val_errors + other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
